//--- cpu900.f
cpu900_pkg.sv
cpu900_regs.sv
cpu900_alu.sv
cpu900_pc.sv
cpu900_ramctl.sv
cpu900_ctrl.sv
cpu900.sv
cpu900_props.sv
cpu900_tb.sv

//--- cpu900.sv
`timescale 1ns/1ps

module cpu900 import cpu900_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    output logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_dout,
    output logic [data_w-1:0] ram_din,
    output logic [1:0]        ram_we,

    // register dump
    input  logic [7:0]        dmp_addr,
    output logic [7:0]        dmp_din,

    output logic              halted
);

    // control strobes
    logic                 pc_inc, pc_we, pc_rel;
    logic                 reg_we, reg_wsel, flag_we;
    logic                 addr_sel, st_en;
    logic [reg_sel_w-1:0] rd_sel, rs_sel;
    alu_sel_t             alu_sel;

    // data paths
    logic [data_w-1:0]    imm, alu_dout, mem_dout;
    logic [data_w-1:0]    src_out, dst_out;
    logic [flags_w-1:0]   flags;
    logic [addr_w-1:0]    pc;

    cpu900_ctrl u_ctrl (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .cen      ( cen      ),
        .instr    ( mem_dout ),
        .flags    ( flags    ),
        .pc_inc   ( pc_inc   ), .pc_we    ( pc_we    ), .pc_rel   ( pc_rel   ),
        .reg_we   ( reg_we   ), .reg_wsel ( reg_wsel ),
        .rd_sel   ( rd_sel   ), .rs_sel   ( rs_sel   ),
        .alu_sel  ( alu_sel  ), .flag_we  ( flag_we  ),
        .imm      ( imm      ),
        .addr_sel ( addr_sel ), .st_en    ( st_en    ),
        .halted   ( halted   )
    );

    cpu900_regs u_regs (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .cen      ( cen      ),
        .rd_sel   ( rd_sel   ), .rs_sel   ( rs_sel   ),
        .we       ( reg_we   ), .wsel     ( reg_wsel ),
        .alu_dout ( alu_dout ), .mem_dout ( mem_dout ),
        .flags    ( flags    ),
        .dst_out  ( dst_out  ), .src_out  ( src_out  ),
        .dmp_addr ( dmp_addr ), .dmp_din  ( dmp_din  )
    );

    cpu900_alu u_alu (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .cen      ( cen      ),
        .op0      ( dst_out  ), .op1      ( src_out  ),
        .imm      ( imm      ),
        .sel      ( alu_sel  ), .flag_we  ( flag_we  ),
        .dout     ( alu_dout ), .flags    ( flags    )
    );

    cpu900_pc u_pc (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .cen      ( cen      ),
        .inc      ( pc_inc   ), .we       ( pc_we    ), .rel      ( pc_rel   ),
        .target   ( src_out  ),              // jr takes rs
        .offset   ( imm      ),
        .pc       ( pc       )
    );

    cpu900_ramctl u_ramctl (
        .clk      ( clk      ), .rst_n    ( rst_n    ), .cen      ( cen      ),
        .pc       ( pc       ),
        .ea       ( src_out  ),              // address held in rs
        .addr_sel ( addr_sel ), .st_en    ( st_en    ),
        .wdata    ( dst_out  ),
        .ram_addr ( ram_addr ), .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ), .ram_we   ( ram_we   ),
        .mem_dout ( mem_dout )
    );

endmodule

//--- cpu900_alu.sv
`timescale 1ns/1ps

module cpu900_alu import cpu900_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,

    input  logic [data_w-1:0]  op0,      // rd
    input  logic [data_w-1:0]  op1,      // rs
    input  logic [data_w-1:0]  imm,
    input  alu_sel_t           sel,
    input  logic               flag_we,

    output logic [data_w-1:0]  dout,
    output logic [flags_w-1:0] flags
);

    logic [data_w:0]    wide;       // top bit is carry or borrow
    logic [flags_w-1:0] flags_nxt;

    always_comb begin
        case (sel)
            alu_add: wide = {1'b0, op0} + {1'b0, op1};
            alu_sub: wide = {1'b0, op0} - {1'b0, op1};  // wraps, top bit set when op0 < op1
            alu_and: wide = {1'b0, op0 & op1};
            alu_or:  wide = {1'b0, op0 | op1};
            alu_xor: wide = {1'b0, op0 ^ op1};
            default: wide = {1'b0, imm};
        endcase
    end

    assign dout = wide[data_w-1:0];

    // logic ops leave the top bit clear, so C drops
    always_comb begin
        flags_nxt         = '0;
        flags_nxt[flag_z] = (dout == '0);
        flags_nxt[flag_c] = wide[data_w];
        flags_nxt[flag_n] = dout[data_w-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (cen && flag_we) begin
            flags <= flags_nxt;
        end
    end

endmodule

//--- cpu900_ctrl.sv
`timescale 1ns/1ps

module cpu900_ctrl import cpu900_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,

    input  logic [data_w-1:0]    instr,
    input  logic [flags_w-1:0]   flags,

    output logic                 pc_inc,
    output logic                 pc_we,
    output logic                 pc_rel,
    output logic                 reg_we,
    output logic                 reg_wsel,
    output logic [reg_sel_w-1:0] rd_sel,
    output logic [reg_sel_w-1:0] rs_sel,
    output alu_sel_t             alu_sel,
    output logic                 flag_we,
    output logic [data_w-1:0]    imm,
    output logic                 addr_sel,
    output logic                 st_en,
    output logic                 halted
);

    state_t            state;
    state_t            state_nxt;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] cur;       // instruction being decoded
    logic [3:0]        opcode;
    logic              is_mem;

    // fetched word shows up on instr during exec, mem and wb use the copy
    assign cur    = (state == exec) ? instr : ir;
    assign opcode = cur[op_hi:op_lo];
    assign rd_sel = cur[rd_hi:rd_lo];
    assign rs_sel = cur[rs_hi:rs_lo];
    assign is_mem = (opcode == op_ld) || (opcode == op_st);
    assign halted = (state == halt);

    // only the branch offset is signed
    assign imm = (opcode == op_jz) ? {{(data_w-imm_w){cur[imm_w-1]}}, cur[imm_w-1:0]}
                                   : {{(data_w-imm_w){1'b0}}, cur[imm_w-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetch;
            ir    <= '0;
        end else if (cen) begin
            state <= state_nxt;
            if (state == exec) begin
                ir <= instr;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            fetch:  state_nxt = decode;
            decode: state_nxt = exec;   // waiting on the RAM read
            exec: begin
                if (opcode == op_halt) begin
                    state_nxt = halt;
                end else if (is_mem) begin
                    state_nxt = mem;
                end else begin
                    state_nxt = fetch;
                end
            end
            mem:     state_nxt = wb;
            wb:      state_nxt = fetch;
            halt:    state_nxt = halt;   // left only through reset
            default: state_nxt = fetch;
        endcase
    end

    always_comb begin
        case (opcode)
            op_add:  alu_sel = alu_add;
            op_sub:  alu_sel = alu_sub;
            op_and:  alu_sel = alu_and;
            op_or:   alu_sel = alu_or;
            op_xor:  alu_sel = alu_xor;
            default: alu_sel = alu_pass;   // ldi
        endcase
    end

    always_comb begin
        pc_inc   = 1'b0;
        pc_we    = 1'b0;
        pc_rel   = 1'b0;
        reg_we   = 1'b0;
        reg_wsel = wsel_alu;
        flag_we  = 1'b0;
        addr_sel = 1'b0;
        st_en    = 1'b0;
        case (state)
            fetch: pc_inc = 1'b1;
            exec: begin
                case (opcode)
                    op_ldi: reg_we = 1'b1;       // flags untouched
                    op_add, op_sub, op_and, op_or, op_xor: begin
                        reg_we  = 1'b1;
                        flag_we = 1'b1;
                    end
                    op_ld: addr_sel = 1'b1;
                    op_st: begin
                        addr_sel = 1'b1;
                        st_en    = 1'b1;
                    end
                    op_jr:   pc_we  = 1'b1;
                    op_jz:   pc_rel = flags[flag_z];
                    op_nop:  ;
                    default: ;                   // halt and spare codes
                endcase
            end
            wb: begin
                if (opcode == op_ld) begin
                    reg_we   = 1'b1;
                    reg_wsel = wsel_mem;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- cpu900_pc.sv
`timescale 1ns/1ps

module cpu900_pc import cpu900_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    input  logic              inc,
    input  logic              we,      // absolute jump
    input  logic              rel,     // relative branch
    input  logic [data_w-1:0] target,
    input  logic [data_w-1:0] offset,

    output logic [addr_w-1:0] pc
);

    logic [addr_w-1:0] offset_sx;

    assign offset_sx = {{(addr_w-data_w){offset[data_w-1]}}, offset};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (cen) begin
            if (we) begin
                pc <= {{(addr_w-data_w){1'b0}}, target};
            end else if (rel) begin
                pc <= pc + offset_sx;   // pc already points past the branch
            end else if (inc) begin
                pc <= pc + addr_w'(1);
            end
        end
    end

endmodule

//--- cpu900_pkg.sv
package cpu900_pkg;

    localparam int data_w    = 16;
    localparam int addr_w    = 24;   // RAM word address
    localparam int reg_n     = 8;
    localparam int reg_sel_w = 3;
    localparam int flags_w   = 8;
    localparam int imm_w     = 8;

    // instruction word fields
    localparam int op_hi = 15;
    localparam int op_lo = 12;
    localparam int rd_hi = 11;
    localparam int rd_lo = 9;
    localparam int rs_hi = 8;
    localparam int rs_lo = 6;

    // opcodes, 12 to 15 behave as nop
    localparam logic [3:0] op_nop  = 4'd0;
    localparam logic [3:0] op_ldi  = 4'd1;
    localparam logic [3:0] op_add  = 4'd2;
    localparam logic [3:0] op_sub  = 4'd3;
    localparam logic [3:0] op_and  = 4'd4;
    localparam logic [3:0] op_or   = 4'd5;
    localparam logic [3:0] op_xor  = 4'd6;
    localparam logic [3:0] op_ld   = 4'd7;
    localparam logic [3:0] op_st   = 4'd8;
    localparam logic [3:0] op_jr   = 4'd9;
    localparam logic [3:0] op_jz   = 4'd10;
    localparam logic [3:0] op_halt = 4'd11;

    localparam int flag_z = 0;
    localparam int flag_c = 1;
    localparam int flag_n = 2;

    localparam logic [7:0] dmp_flags = 8'd16;  // dump address of the flag byte

    // register write source
    localparam logic wsel_alu = 1'b0;
    localparam logic wsel_mem = 1'b1;

    typedef enum logic [2:0] {
        alu_pass, alu_add, alu_sub, alu_and, alu_or, alu_xor
    } alu_sel_t;

    typedef enum logic [2:0] {
        fetch, decode, exec, mem, wb, halt
    } state_t;

endpackage

//--- cpu900_props.sv
`timescale 1ns/1ps

module cpu900_props (
    input logic       clk,
    input logic       rst_n,
    input logic       cen,
    input logic [1:0] ram_we,
    input logic       halted
);

    logic we_seen;   // store strobe on the last enabled edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_seen <= 1'b0;
        end else if (cen) begin
            we_seen <= (ram_we != 2'b00);
        end
    end

    // one store strobe per ST
    assert property (@(posedge clk) disable iff (!rst_n) (cen && we_seen) |-> ram_we == 2'b00)
        else $error("ram_we high on two enabled cycles in a row");

    assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without a reset");

    assert property (@(posedge clk) disable iff (!rst_n) halted |-> ram_we == 2'b00)
        else $error("ram_we active while halted");

endmodule

bind cpu900 cpu900_props u_props (
    .clk    ( clk    ),
    .rst_n  ( rst_n  ),
    .cen    ( cen    ),
    .ram_we ( ram_we ),
    .halted ( halted )
);

//--- cpu900_ramctl.sv
`timescale 1ns/1ps

module cpu900_ramctl import cpu900_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,

    input  logic [addr_w-1:0] pc,
    input  logic [data_w-1:0] ea,        // data address from rs
    input  logic              addr_sel,  // 1 selects ea
    input  logic              st_en,
    input  logic [data_w-1:0] wdata,

    // RAM interface
    output logic [addr_w-1:0] ram_addr,
    input  logic [data_w-1:0] ram_dout,
    output logic [data_w-1:0] ram_din,
    output logic [1:0]        ram_we,

    output logic [data_w-1:0] mem_dout
);

    assign ram_addr = addr_sel ? {{(addr_w-data_w){1'b0}}, ea} : pc;
    assign ram_din  = wdata;
    assign ram_we   = st_en ? 2'b11 : 2'b00;   // word stores only

    // the RAM registers its read on the edge after the address,
    // the word is taken here one enabled edge later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_dout <= '0;   // decodes as nop
        end else if (cen) begin
            mem_dout <= ram_dout;
        end
    end

endmodule

//--- cpu900_regs.sv
`timescale 1ns/1ps

module cpu900_regs import cpu900_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen,

    input  logic [reg_sel_w-1:0] rd_sel,
    input  logic [reg_sel_w-1:0] rs_sel,
    input  logic                 we,
    input  logic                 wsel,
    input  logic [data_w-1:0]    alu_dout,
    input  logic [data_w-1:0]    mem_dout,
    input  logic [flags_w-1:0]   flags,

    output logic [data_w-1:0]    dst_out,
    output logic [data_w-1:0]    src_out,

    // register dump
    input  logic [7:0]           dmp_addr,
    output logic [7:0]           dmp_din
);

    logic [data_w-1:0] regs [reg_n];
    logic [data_w-1:0] wdata;
    logic [data_w-1:0] dmp_word;

    assign wdata = (wsel == wsel_mem) ? mem_dout : alu_dout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_n; i++) begin
                regs[i] <= '0;
            end
        end else if (cen && we) begin
            regs[rd_sel] <= wdata;
        end
    end

    assign dst_out = regs[rd_sel];
    assign src_out = regs[rs_sel];

    // two dump bytes per register
    assign dmp_word = regs[dmp_addr[reg_sel_w:1]];

    always_comb begin
        if (dmp_addr < dmp_flags) begin
            dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];  // even is low byte
        end else if (dmp_addr == dmp_flags) begin
            dmp_din = flags;
        end else begin
            dmp_din = 8'h00;
        end
    end

endmodule

//--- cpu900_tb.sv
`timescale 1ns/1ps

module cpu900_tb import cpu900_pkg::*; ();

    localparam int n_tests    = 6;
    localparam int max_cycles = n_tests * (12 * 5 * 4 + 5 + 20 + 40) + 500;
    localparam logic [15:0] hlt = {op_halt, 12'h000};

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        cen = 1'b0;
    logic [7:0]  dmp_addr = 8'h00;
    logic [23:0] ram_addr;
    logic [15:0] ram_din;
    logic [15:0] ram_dout = 16'h0000;
    logic [1:0]  ram_we;
    logic [7:0]  dmp_din;
    logic        halted;

    logic [15:0] ram [256];
    logic [15:0] img [256];      // loaded into the RAM during reset
    logic [15:0] prog [n_tests][12];
    logic [15:0] exp_r [n_tests][8];
    logic [7:0]  exp_f [n_tests];
    logic        mem_chk [n_tests];
    logic [15:0] mem_val [n_tests];
    logic [31:0] lfsr = 32'ha2ed_e761;
    logic        bit_a;
    int          cycles = 0;
    int          errors = 0;
    int          passed = 0;

    cpu900 dut0 (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .ram_addr(ram_addr), .ram_dout(ram_dout), .ram_din(ram_din), .ram_we(ram_we),
        .dmp_addr(dmp_addr), .dmp_din(dmp_din), .halted(halted)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    // high three cycles in four from two lfsr bits
    always @(posedge clk) begin
        #2;
        lfsr = lfsr_step(lfsr);
        bit_a = lfsr[0];
        lfsr = lfsr_step(lfsr);
        cen = ~(bit_a & lfsr[0]);
    end

    // RAM model with registered read and byte writes on the clock enable
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                ram[i] <= img[i];
            end
            ram_dout <= 16'h0000;
        end else if (cen) begin
            if (ram_we[0]) ram[ram_addr[7:0]][7:0] <= ram_din[7:0];
            if (ram_we[1]) ram[ram_addr[7:0]][15:8] <= ram_din[15:8];
            ram_dout <= ram[ram_addr[7:0]];
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: program did not halt within %0d cycles", max_cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [15:0] ldi(input int rd, input int imm);
        return {op_ldi, 3'(rd), 1'b0, 8'(imm)};
    endfunction

    function automatic logic [15:0] rr(input logic [3:0] op, input int rd, input int rs);
        return {op, 3'(rd), 3'(rs), 6'h00};
    endfunction

    function automatic logic [15:0] jz(input int off);
        return {op_jz, 4'h0, 8'(off)};   // offset from the next instruction
    endfunction

    task automatic init_table();
        prog[0] = '{ldi(1, 'hf0), ldi(2, 'h20), rr(op_add, 1, 2), rr(op_sub, 2, 1),
                    rr(op_add, 2, 1), ldi(3, 'h05), ldi(4, 'h05), rr(op_sub, 3, 4),
                    jz('h01), ldi(5, 'hee), rr(op_sub, 4, 1), hlt};
        exp_r[0] = '{16'h0, 16'h0110, 16'h0020, 16'h0, 16'hfef5, 16'h0, 16'h0, 16'h0};
        exp_f[0] = 8'h06;   // borrow and negative from the last sub
        prog[1] = '{ldi(1, 'hf0), ldi(2, 'h3c), rr(op_and, 1, 2), ldi(3, 'h55),
                    rr(op_xor, 3, 2), ldi(5, 'h01), rr(op_sub, 0, 5), rr(op_and, 0, 2),
                    hlt, hlt, hlt, hlt};
        exp_r[1] = '{16'h003c, 16'h0030, 16'h003c, 16'h0069, 16'h0, 16'h0001, 16'h0, 16'h0};
        exp_f[1] = 8'h00;   // borrow cleared by and
        prog[2] = '{ldi(1, 'h80), rr(op_add, 1, 1), rr(op_add, 1, 1), rr(op_add, 1, 1),
                    rr(op_add, 1, 1), rr(op_add, 1, 1), rr(op_add, 1, 1), rr(op_add, 1, 1),
                    rr(op_add, 1, 1), ldi(2, 'h0f), rr(op_or, 2, 1), hlt};
        exp_r[2] = '{16'h0, 16'h8000, 16'h800f, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
        exp_f[2] = 8'h04;
        prog[3] = '{ldi(1, 'ha5), rr(op_add, 1, 1), ldi(2, 'h40), rr(op_st, 1, 2),
                    ldi(3, 'h40), rr(op_ld, 4, 3), hlt, hlt, hlt, hlt, hlt, hlt};
        exp_r[3] = '{16'h0, 16'h014a, 16'h0040, 16'h0040, 16'h014a, 16'h0, 16'h0, 16'h0};
        exp_f[3] = 8'h00;
        prog[4] = '{ldi(1, 'h01), rr(op_sub, 1, 1), jz('h01), ldi(3, 'h33),
                    ldi(4, 'h09), rr(op_jr, 0, 4), ldi(5, 'h55), ldi(6, 'h66),
                    hlt, rr(op_add, 4, 4), jz('hfe), hlt};
        exp_r[4] = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h0012, 16'h0, 16'h0, 16'h0};
        exp_f[4] = 8'h00;
        prog[5] = '{ldi(7, 'h07), hlt, ldi(7, 'h08), hlt, hlt, hlt, hlt, hlt,
                    hlt, hlt, hlt, hlt};
        exp_r[5] = '{16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0007};
        exp_f[5] = 8'h00;
        for (int t = 0; t < n_tests; t++) begin
            mem_chk[t] = (t == 3);   // only the store test
            mem_val[t] = 16'h014a;
        end
    endtask

    task automatic read_dump(input logic [7:0] a, output logic [7:0] v);
        @(posedge clk);
        #2 dmp_addr = a;
        @(negedge clk);
        v = dmp_din;
    endtask

    task automatic run_test(input int t);
        int          errs;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  fl;
        errs = 0;
        @(posedge clk);
        #2 rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            img[i] = (i < 12) ? prog[t][i] : {8'hc0, 8'(i)};   // spare opcode fill
        end
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        while (!halted) @(negedge clk);
        repeat (20) @(posedge clk);
        for (int r = 0; r < 8; r++) begin
            read_dump(8'(2 * r), lo);
            read_dump(8'(2 * r + 1), hi);
            if ({hi, lo} != exp_r[t][r]) begin
                $display("[FAIL] test %0d dmp_din r%0d: got %h expected %h",
                         t, r, {hi, lo}, exp_r[t][r]);
                errs++;
            end
        end
        read_dump(dmp_flags, fl);
        if (fl != exp_f[t]) begin
            $display("[FAIL] test %0d dmp_din flags: got %h expected %h", t, fl, exp_f[t]);
            errs++;
        end
        if (!halted) begin
            $display("test %0d: halted dropped while the core should stay stopped", t);
            errs++;
        end
        if (mem_chk[t] && ram[8'h40] != mem_val[t]) begin
            $display("[FAIL] test %0d ram[40]: got %h expected %h", t, ram[8'h40], mem_val[t]);
            errs++;
        end
        errors += errs;
        if (errs == 0) passed++;
        $display("test %0d %s, %0d errors", t, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        init_table();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, errors %0d", n_tests, passed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the cpu900 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpu900.f --top-module cpu900_tb -o cpu900_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/cpu900_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
